/* mips_cpu.f */
mips_cpu_pkg.sv
mips_regfile.sv
mips_execute.sv
mips_load_store.sv
mips_bus_sequencer.sv
mips_cpu_bus.sv
mips_tb_memory.sv
mips_cpu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
rm -f sim.log
verilator --binary --timing --top-module mips_cpu_tb -f mips_cpu.f -o mips_cpu_sim \
    && ./obj_dir/mips_cpu_sim > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "No errors" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* mips_cpu_tb.sv */
module mips_cpu_tb
    import mips_cpu_pkg::*;
();

    localparam word_t RESET_VECTOR = 32'hBFC00000;
    localparam word_t DATA_BASE    = 32'h00001000;

    logic       clk;
    logic       reset;
    logic       stall_en;
    logic       active;
    word_t      register_v0;
    word_t      address;
    logic       write;
    logic       read;
    logic       waitrequest;
    word_t      writedata;
    logic [3:0] byteenable;
    word_t      readdata;
    int         writes_seen;

    word_t    rng;
    word_t    prog [$];
    word_t    model_mem [word_t];
    word_t    read_q [$];
    bus_req_t store_q [$];
    int       total_stores;
    logic     checking;
    logic     prev_stall;
    bus_req_t prev_req;

    mips_cpu_bus #(
        .RESET_VECTOR(RESET_VECTOR)
    ) dut_i (
        .clk(clk),
        .reset(reset),
        .active(active),
        .register_v0(register_v0),
        .address(address),
        .write(write),
        .read(read),
        .waitrequest(waitrequest),
        .writedata(writedata),
        .byteenable(byteenable),
        .readdata(readdata)
    );

    mips_tb_memory #(
        .SEED(32'hb47b_c317)
    ) mem_i (
        .clk(clk),
        .reset(reset),
        .stall_en(stall_en),
        .address(address),
        .read(read),
        .write(write),
        .writedata(writedata),
        .byteenable(byteenable),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .writes_seen(writes_seen)
    );

    always #4 clk = ~clk;

    function automatic word_t xorshift(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function word_t next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    function automatic word_t fill_word(word_t a);
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t model_read(word_t a);
        if (model_mem.exists(a)) begin
            return model_mem[a];
        end
        return fill_word(a);
    endfunction

    function automatic word_t enc_r(function_t f, int rs, int rt, int rd);
        return {OPCODE_R, 5'(rs), 5'(rt), 5'(rd), 5'd0, f};
    endfunction

    function automatic word_t enc_i(opcode_t op, int rs, int rt, logic [15:0] imm);
        return {op, 5'(rs), 5'(rt), imm};
    endfunction

    task automatic report_fail(string line);
        $display("%s", line);
        $display("Errors found");
        $fatal(1);
    endtask

    task automatic check_word(string name, word_t got, word_t exp);
        if (got !== exp) begin
            report_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    task automatic check_req(string name, bus_req_t got, bus_req_t exp);
        if (got !== exp) begin
            report_fail($sformatf("Fail %s: got %h, expected %h", name, got, exp));
        end
    endtask

    // Mode 0 is ALU only, mode 1 adds LW/SW, mode 2 adds branches and jumps
    task automatic gen_program(int mode, int body);
        int    last;
        int    t;
        int    kind;
        int    ra;
        int    rb;
        logic  prev_branch;
        word_t r;
        word_t ja;
        prog.delete();
        prog.push_back(enc_i(OPCODE_LUI, 0, 1, 16'h0000));
        prog.push_back(enc_i(OPCODE_ORI, 1, 1, DATA_BASE[15:0]));
        last = 2 + body;
        prev_branch = 1'b0;
        for (int i = 2; i < last; i++) begin
            r = next_rand();
            if (mode == 2 && !prev_branch && i <= last - 2 && r[3:0] < 4'd5) begin
                t    = i + 2 + int'((r >> 8) % 32'd3);
                t    = (t > last) ? last : t;
                kind = int'((r >> 4) % 32'd8);
                ja   = RESET_VECTOR + word_t'(4 * t);
                ra   = int'(r[12:10]);
                rb   = int'(r[15:13]);
                case (kind)
                    0: prog.push_back(enc_i(OPCODE_BEQ, ra, rb, 16'(t - i - 1)));
                    1: prog.push_back(enc_i(OPCODE_BNE, ra, rb, 16'(t - i - 1)));
                    2: prog.push_back(enc_i(OPCODE_BGTZ, ra, 0, 16'(t - i - 1)));
                    3: prog.push_back(enc_i(OPCODE_BLEZ, ra, 0, 16'(t - i - 1)));
                    4: prog.push_back(enc_i(OPCODE_REGIMM, ra, 1, 16'(t - i - 1)));
                    5: prog.push_back(enc_i(OPCODE_REGIMM, ra, 0, 16'(t - i - 1)));
                    6: prog.push_back({OPCODE_J, ja[27:2]});
                    default: prog.push_back({OPCODE_JAL, ja[27:2]});
                endcase
                prev_branch = 1'b1;
            end else if (mode == 1 && r[3:0] < 4'd6) begin
                if (r[4]) begin
                    prog.push_back(enc_i(OPCODE_LW, 1, 2 + int'((r >> 12) % 32'd6),
                                         {10'd0, r[11:8], 2'b00}));
                end else begin
                    prog.push_back(enc_i(OPCODE_SW, 1, int'(r[14:12]),
                                         {10'd0, r[11:8], 2'b00}));
                end
                prev_branch = 1'b0;
            end else begin
                kind = int'((r >> 4) % 32'd9);
                t    = 2 + int'((r >> 8) % 32'd6);
                ra   = int'(r[13:11]);
                rb   = int'(r[16:14]);
                case (kind)
                    0: prog.push_back(enc_r(FUNCTION_ADDU, ra, rb, t));
                    1: prog.push_back(enc_r(FUNCTION_SUBU, ra, rb, t));
                    2: prog.push_back(enc_r(FUNCTION_AND, ra, rb, t));
                    3: prog.push_back(enc_r(FUNCTION_OR, ra, rb, t));
                    4: prog.push_back(enc_r(FUNCTION_XOR, ra, rb, t));
                    5: prog.push_back(enc_i(OPCODE_ADDIU, ra, t, r[31:16]));
                    6: prog.push_back(enc_i(OPCODE_ANDI, ra, t, r[31:16]));
                    7: prog.push_back(enc_i(OPCODE_ORI, ra, t, r[31:16]));
                    default: prog.push_back(enc_i(OPCODE_LUI, 0, t, r[31:16]));
                endcase
                prev_branch = 1'b0;
            end
        end
        // Fold the JAL link register into v0
        prog.push_back(enc_r(FUNCTION_XOR, 2, 31, 2));
        // JR $0 ends the program, with a nop in its delay slot
        prog.push_back(enc_r(FUNCTION_JR, 0, 0, 0));
        prog.push_back(32'h0000_0000);
    endtask

    // Instruction-set interpreter with one delay slot
    task automatic run_model(output word_t v0);
        word_t regs [32];
        word_t pc;
        word_t w;
        word_t a;
        word_t b;
        word_t sx;
        word_t nxt;
        word_t tgt;
        logic  pend;
        logic  take;
        int    steps;
        for (int k = 0; k < 32; k++) begin
            regs[k] = '0;
        end
        pc    = RESET_VECTOR;
        pend  = 1'b0;
        tgt   = '0;
        steps = 0;
        read_q.delete();
        store_q.delete();
        while (pc != '0) begin
            steps++;
            if (steps > 1000) begin
                report_fail("Reference model did not reach the halt address");
            end
            read_q.push_back(pc);
            w    = model_read(pc);
            a    = regs[w[25:21]];
            b    = regs[w[20:16]];
            sx   = {{16{w[15]}}, w[15:0]};
            nxt  = pend ? tgt : pc + 32'd4;
            take = 1'b0;
            case (opcode_t'(w[31:26]))
                OPCODE_R: begin
                    case (function_t'(w[5:0]))
                        FUNCTION_ADDU: regs[w[15:11]] = a + b;
                        FUNCTION_SUBU: regs[w[15:11]] = a - b;
                        FUNCTION_AND:  regs[w[15:11]] = a & b;
                        FUNCTION_OR:   regs[w[15:11]] = a | b;
                        FUNCTION_XOR:  regs[w[15:11]] = a ^ b;
                        FUNCTION_JR: begin
                            take = 1'b1;
                            tgt  = a;
                        end
                        default: ;
                    endcase
                end
                OPCODE_ADDIU: regs[w[20:16]] = a + sx;
                OPCODE_ANDI:  regs[w[20:16]] = a & {16'h0000, w[15:0]};
                OPCODE_ORI:   regs[w[20:16]] = a | {16'h0000, w[15:0]};
                OPCODE_LUI:   regs[w[20:16]] = {w[15:0], 16'h0000};
                OPCODE_LW: begin
                    read_q.push_back(a + sx);
                    regs[w[20:16]] = model_read(a + sx);
                end
                OPCODE_SW: begin
                    model_mem[a + sx] = b;
                    store_q.push_back('{address: a + sx, read: 1'b0, write: 1'b1,
                                        writedata: b, byteenable: 4'hf});
                end
                OPCODE_J, OPCODE_JAL: begin
                    take = 1'b1;
                    tgt  = {pc[31:28] + 4'(pc[27:2] == 26'h3ffffff), w[25:0], 2'b00};
                    if (w[31:26] == OPCODE_JAL) begin
                        regs[31] = pc + 32'd8;
                    end
                end
                default: begin
                    if (w[31:26] != OPCODE_REGIMM) begin
                        case (w[31:26])
                            OPCODE_BEQ:  take = (a == b);
                            OPCODE_BNE:  take = (a != b);
                            OPCODE_BGTZ: take = $signed(a) > 0;
                            OPCODE_BLEZ: take = $signed(a) <= 0;
                            default: ;
                        endcase
                    end else begin
                        take = (w[20:16] == 5'd1) ? !a[31] : a[31];
                    end
                    tgt = pc + 32'd4 + (sx << 2);
                end
            endcase
            regs[0] = '0;
            pend    = take;
            pc      = nxt;
        end
        v0 = regs[2];
    endtask

    // Bus monitor comparing DUT requests with the model's expected traffic
    always @(posedge clk) begin
        bus_req_t cur;
        word_t    exp_addr;
        if (checking) begin
            cur = '{address: address, read: read, write: write,
                    writedata: writedata, byteenable: byteenable};
            if (prev_stall) begin
                check_req("stalled request", cur, prev_req);
            end
            if (read && write) begin
                report_fail("The DUT asserted read and write in the same cycle");
            end
            if (read && !waitrequest) begin
                if (read_q.size() == 0) begin
                    report_fail($sformatf("Unexpected read of address %h", address));
                end
                exp_addr = read_q.pop_front();
                check_word("read address", address, exp_addr);
                check_word("read byteenable", {28'd0, byteenable}, 32'h0000_000f);
            end
            if (write && !waitrequest) begin
                if (store_q.size() == 0) begin
                    report_fail($sformatf("Unexpected write to address %h", address));
                end
                check_req("write request", cur, store_q.pop_front());
            end
            prev_req   = cur;
            prev_stall = (read || write) && waitrequest;
        end else begin
            prev_stall = 1'b0;
        end
    end

    task automatic run_test(int mode, logic stall, int body);
        word_t    exp_v0;
        bus_req_t first_req;
        bus_req_t exp_first;
        int       cycles;
        int       limit;
        gen_program(mode, body);
        for (int k = 0; k < prog.size(); k++) begin
            model_mem[RESET_VECTOR + word_t'(4 * k)] = prog[k];
            mem_i.store_word(RESET_VECTOR + word_t'(4 * k), prog[k]);
        end
        run_model(exp_v0);
        total_stores += store_q.size();
        limit = prog.size() * 12 + 200;
        @(posedge clk);
        #1;
        checking = 1'b0;
        reset    = 1'b1;
        stall_en = stall;
        repeat (4) @(posedge clk);
        #1;
        reset    = 1'b0;
        checking = 1'b1;
        #2;
        // First request after reset is the fetch at the reset vector
        // Write data carries no meaning on a read
        first_req = '{address: address, read: read, write: write,
                      writedata: '0, byteenable: byteenable};
        exp_first = '{address: RESET_VECTOR, read: 1'b1, write: 1'b0,
                      writedata: '0, byteenable: 4'hf};
        check_req("first request", first_req, exp_first);
        check_word("active", {31'd0, active}, 32'd1);
        cycles = 0;
        while (active) begin
            @(posedge clk);
            cycles++;
            if (cycles > limit) begin
                report_fail($sformatf("Timeout: no halt after %0d cycles", cycles));
            end
        end
        check_word("register_v0", register_v0, exp_v0);
        check_word("pending reads", read_q.size(), 0);
        check_word("pending writes", store_q.size(), 0);
        check_word("writes_seen", writes_seen, total_stores);
        repeat (20) begin
            @(posedge clk);
            check_word("active after halt", {31'd0, active}, 32'd0);
            check_word("read after halt", {31'd0, read}, 32'd0);
            check_word("write after halt", {31'd0, write}, 32'd0);
        end
        checking = 1'b0;
    endtask

    initial begin
        clk          = 1'b0;
        reset        = 1'b1;
        stall_en     = 1'b0;
        checking     = 1'b0;
        prev_stall   = 1'b0;
        total_stores = 0;
        rng          = 32'hb47b_c317;
        for (int t = 0; t < 12; t++) begin
            run_test(t % 3, t >= 6, 24 + 2 * t);
        end
        $display("No errors");
        $finish;
    end

endmodule

/* mips_tb_memory.sv */
module mips_tb_memory
    import mips_cpu_pkg::*;
#(
    parameter word_t SEED = 32'h1
) (
    input  logic       clk,
    input  logic       reset,
    input  logic       stall_en,
    input  word_t      address,
    input  logic       read,
    input  logic       write,
    input  word_t      writedata,
    input  logic [3:0] byteenable,
    output logic       waitrequest,
    output word_t      readdata,
    output int         writes_seen
);

    word_t mem [word_t];
    word_t rng = SEED;
    int    wait_left;
    logic  busy;
    logic  rst_q;

    function automatic word_t xorshift(word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Unwritten words read back as a pattern of their own address
    function automatic word_t fill_word(word_t a);
        return ~a ^ {a[15:0], a[31:16]};
    endfunction

    function automatic word_t lookup(word_t a);
        if (mem.exists(a)) begin
            return mem[a];
        end
        return fill_word(a);
    endfunction

    task automatic store_word(word_t a, word_t d);
        mem[a] = d;
    endtask

    initial begin
        waitrequest = 1'b0;
        readdata    = '0;
        writes_seen = 0;
        busy        = 1'b0;
        wait_left   = 0;
    end

    always @(posedge clk) begin
        word_t merged;
        rst_q = reset;
        if (reset) begin
            busy = 1'b0;
        end else if ((read || write) && !waitrequest) begin
            if (write) begin
                merged = lookup(address);
                for (int b = 0; b < 4; b++) begin
                    if (byteenable[b]) begin
                        merged[b*8 +: 8] = writedata[b*8 +: 8];
                    end
                end
                mem[address] = merged;
                writes_seen++;
            end
            busy = 1'b0;
        end
        #1;
        // A new request draws its own number of wait cycles
        if (!rst_q && (read || write)) begin
            if (!busy) begin
                busy      = 1'b1;
                rng       = xorshift(rng);
                wait_left = stall_en ? int'(rng % 32'd4) : 0;
            end else if (wait_left > 0) begin
                wait_left--;
            end
        end else begin
            busy      = 1'b0;
            wait_left = 0;
        end
        waitrequest = (wait_left != 0);
        readdata    = read ? lookup(address) : '0;
    end

endmodule

/* mips_cpu_bus.sv */
module mips_cpu_bus
    import mips_cpu_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic       clk,
    input  logic       reset,
    output logic       active,
    output word_t      register_v0,

    // Avalon master
    output word_t      address,
    output logic       write,
    output logic       read,
    input  logic       waitrequest,
    output word_t      writedata,
    output logic [3:0] byteenable,
    input  word_t      readdata
);

    instr_t   ir;
    word_t    pc;
    logic     exec_fire;
    logic     taken;
    word_t    target;
    logic     is_mem;
    reg_wr_t  alu_wr;
    reg_wr_t  load_wr;
    reg_wr_t  rf_wr;
    bus_req_t mem_req;
    bus_req_t bus_req;
    word_t    rs_val;
    word_t    rt_val;

    mips_bus_sequencer #(
        .RESET_VECTOR(RESET_VECTOR)
    ) seq_i (
        .clk(clk),
        .reset(reset),
        .waitrequest(waitrequest),
        .readdata(readdata),
        .taken(taken),
        .target(target),
        .is_mem(is_mem),
        .alu_wr(alu_wr),
        .load_wr(load_wr),
        .mem_req(mem_req),
        .active(active),
        .ir(ir),
        .pc(pc),
        .exec_fire(exec_fire),
        .bus_req(bus_req),
        .rf_wr(rf_wr)
    );

    mips_regfile regfile_i (
        .clk(clk),
        .reset(reset),
        .rs_addr(ir.r.rs),
        .rt_addr(ir.r.rt),
        .wr(rf_wr),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .v0(register_v0)
    );

    mips_execute exec_i (
        .ir(ir),
        .pc(pc),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .exec_fire(exec_fire),
        .taken(taken),
        .target(target),
        .is_mem(is_mem),
        .alu_wr(alu_wr)
    );

    mips_load_store ls_i (
        .ir(ir),
        .rs_val(rs_val),
        .rt_val(rt_val),
        .readdata(readdata),
        .exec_fire(exec_fire),
        .mem_req(mem_req),
        .load_wr(load_wr)
    );

    // Bus request onto the Avalon pins
    assign address    = bus_req.address;
    assign read       = bus_req.read;
    assign write      = bus_req.write;
    assign writedata  = bus_req.writedata;
    assign byteenable = bus_req.byteenable;

endmodule

/* mips_bus_sequencer.sv */
module mips_bus_sequencer
    import mips_cpu_pkg::*;
#(
    parameter word_t RESET_VECTOR = 32'hBFC00000
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     waitrequest,
    input  word_t    readdata,
    input  logic     taken,
    input  word_t    target,
    input  logic     is_mem,
    input  reg_wr_t  alu_wr,
    input  reg_wr_t  load_wr,
    input  bus_req_t mem_req,
    output logic     active,
    output instr_t   ir,
    output word_t    pc,
    output logic     exec_fire,
    output bus_req_t bus_req,
    output reg_wr_t  rf_wr
);

    seq_state_t state;
    word_t      pc_next;
    word_t      pc_jmp;
    logic       delay;

    // Delay slot target replaces pc+4 once the slot instruction retires
    assign pc_next = delay ? pc_jmp : pc + 32'd4;

    assign exec_fire = (state == EXEC) || (state == MEM_ACCESS && !waitrequest);
    assign active    = (state != HALTED);

    // Loads write back on the completing memory cycle, everything else in EXEC
    assign rf_wr = (state == MEM_ACCESS) ? load_wr : alu_wr;

    always_comb begin
        bus_req = '0;
        case (state)
            FETCH: begin
                bus_req.address    = pc;
                // No fetch once pc has reached the halt address
                bus_req.read       = (pc != '0);
                bus_req.byteenable = 4'b1111;
            end
            MEM_ACCESS: begin
                bus_req = mem_req;
            end
            default: begin
                bus_req = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= FETCH;
            pc    <= RESET_VECTOR;
            delay <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    if (pc == '0) begin
                        state <= HALTED;
                    end else if (!waitrequest) begin
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    state <= is_mem ? MEM_ACCESS : FETCH;
                    pc    <= pc_next;
                    delay <= taken;
                end
                MEM_ACCESS: begin
                    if (!waitrequest) begin
                        state <= FETCH;
                    end
                end
                default: begin
                    // Halted until the next reset
                    state <= HALTED;
                end
            endcase
        end
    end

    // Instruction register and pending branch target
    always_ff @(posedge clk) begin
        if (state == FETCH && !waitrequest) begin
            ir <= readdata;
        end
        if (state == EXEC && taken) begin
            pc_jmp <= target;
        end
    end

endmodule

/* mips_load_store.sv */
module mips_load_store
    import mips_cpu_pkg::*;
(
    input  instr_t   ir,
    input  word_t    rs_val,
    input  word_t    rt_val,
    input  word_t    readdata,
    input  logic     exec_fire,
    output bus_req_t mem_req,
    output reg_wr_t  load_wr
);

    word_t eff_addr;
    logic  is_load;
    logic  is_store;

    assign is_load  = (ir.i.opcode == OPCODE_LW);
    assign is_store = (ir.i.opcode == OPCODE_SW);

    // Base register plus signed offset
    assign eff_addr = rs_val + {{16{ir.i.imm[15]}}, ir.i.imm};

    // Depends only on the held instruction and registers, so it is stable across stalls
    always_comb begin
        mem_req.address    = eff_addr;
        mem_req.read       = is_load;
        mem_req.write      = is_store;
        mem_req.writedata  = is_store ? rt_val : '0;
        mem_req.byteenable = 4'b1111;
    end

    // Load result, valid on the completing bus cycle
    always_comb begin
        load_wr.en   = exec_fire && is_load;
        load_wr.addr = ir.i.rt;
        load_wr.data = readdata;
    end

endmodule

/* mips_execute.sv */
module mips_execute
    import mips_cpu_pkg::*;
(
    input  instr_t  ir,
    input  word_t   pc,
    input  word_t   rs_val,
    input  word_t   rt_val,
    input  logic    exec_fire,
    output logic    taken,
    output word_t   target,
    output logic    is_mem,
    output reg_wr_t alu_wr
);

    word_t      pc_plus4;
    word_t      imm_sext;
    word_t      imm_zext;
    word_t      branch_target;
    word_t      result;
    logic       cond;
    logic       wr_en;
    logic [4:0] wr_addr;

    assign pc_plus4      = pc + 32'd4;
    assign imm_sext      = {{16{ir.i.imm[15]}}, ir.i.imm};
    assign imm_zext      = {16'h0000, ir.i.imm};
    assign branch_target = pc_plus4 + {imm_sext[29:0], 2'b00};

    always_comb begin
        cond    = 1'b0;
        target  = branch_target;
        is_mem  = 1'b0;
        result  = '0;
        wr_en   = 1'b0;
        wr_addr = ir.i.rt;
        case (ir.i.opcode)
            OPCODE_R: begin
                wr_addr = ir.r.rd;
                case (ir.r.funct)
                    FUNCTION_ADDU: begin
                        result = rs_val + rt_val;
                        wr_en  = 1'b1;
                    end
                    FUNCTION_SUBU: begin
                        result = rs_val - rt_val;
                        wr_en  = 1'b1;
                    end
                    FUNCTION_AND: begin
                        result = rs_val & rt_val;
                        wr_en  = 1'b1;
                    end
                    FUNCTION_OR: begin
                        result = rs_val | rt_val;
                        wr_en  = 1'b1;
                    end
                    FUNCTION_XOR: begin
                        result = rs_val ^ rt_val;
                        wr_en  = 1'b1;
                    end
                    FUNCTION_JR: begin
                        cond   = 1'b1;
                        target = rs_val;
                    end
                    default: ;
                endcase
            end
            OPCODE_REGIMM: begin
                case (regimm_t'(ir.i.rt))
                    REGIMM_BGEZ: cond = !rs_val[31];
                    REGIMM_BLTZ: cond = rs_val[31];
                    default: ;
                endcase
            end
            OPCODE_BEQ:  cond = (rs_val == rt_val);
            OPCODE_BNE:  cond = (rs_val != rt_val);
            OPCODE_BLEZ: cond = ($signed(rs_val) <= 32'sd0);
            OPCODE_BGTZ: cond = ($signed(rs_val) > 32'sd0);
            OPCODE_J: begin
                cond   = 1'b1;
                target = {pc_plus4[31:28], ir.j.index, 2'b00};
            end
            OPCODE_JAL: begin
                cond    = 1'b1;
                target  = {pc_plus4[31:28], ir.j.index, 2'b00};
                // Return address skips the delay slot
                result  = pc + 32'd8;
                wr_en   = 1'b1;
                wr_addr = 5'd31;
            end
            OPCODE_ADDIU: begin
                result = rs_val + imm_sext;
                wr_en  = 1'b1;
            end
            OPCODE_ANDI: begin
                result = rs_val & imm_zext;
                wr_en  = 1'b1;
            end
            OPCODE_ORI: begin
                result = rs_val | imm_zext;
                wr_en  = 1'b1;
            end
            OPCODE_LUI: begin
                result = {ir.i.imm, 16'h0000};
                wr_en  = 1'b1;
            end
            OPCODE_LW, OPCODE_SW: is_mem = 1'b1;
            // Unknown opcodes fall through as a nop
            default: ;
        endcase
    end

    assign taken = exec_fire && cond;

    assign alu_wr = '{en: exec_fire && wr_en, addr: wr_addr, data: result};

endmodule

/* mips_regfile.sv */
module mips_regfile
    import mips_cpu_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  logic [4:0] rs_addr,
    input  logic [4:0] rt_addr,
    input  reg_wr_t    wr,
    output word_t      rs_val,
    output word_t      rt_val,
    output word_t      v0
);

    // $zero has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && wr.addr != 5'd0) begin
            regs[wr.addr] <= wr.data;
        end
    end

    assign rs_val = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
    assign rt_val = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

    assign v0 = regs[2];

endmodule

/* mips_cpu_pkg.sv */
package mips_cpu_pkg;

    typedef logic [31:0] word_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OPCODE_R      = 6'h00,
        OPCODE_REGIMM = 6'h01,
        OPCODE_J      = 6'h02,
        OPCODE_JAL    = 6'h03,
        OPCODE_BEQ    = 6'h04,
        OPCODE_BNE    = 6'h05,
        OPCODE_BLEZ   = 6'h06,
        OPCODE_BGTZ   = 6'h07,
        OPCODE_ADDIU  = 6'h09,
        OPCODE_ANDI   = 6'h0C,
        OPCODE_ORI    = 6'h0D,
        OPCODE_LUI    = 6'h0F,
        OPCODE_LW     = 6'h23,
        OPCODE_SW     = 6'h2B
    } opcode_t;

    // R-type function field
    typedef enum logic [5:0] {
        FUNCTION_JR   = 6'h08,
        FUNCTION_ADDU = 6'h21,
        FUNCTION_SUBU = 6'h23,
        FUNCTION_AND  = 6'h24,
        FUNCTION_OR   = 6'h25,
        FUNCTION_XOR  = 6'h26
    } function_t;

    // REGIMM branches, selected by the rt field
    typedef enum logic [4:0] {
        REGIMM_BLTZ = 5'h00,
        REGIMM_BGEZ = 5'h01
    } regimm_t;

    typedef enum logic [1:0] {
        FETCH,
        EXEC,
        MEM_ACCESS,
        HALTED
    } seq_state_t;

    typedef struct packed {
        opcode_t    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        function_t  funct;
    } r_instr_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_instr_t;

    typedef struct packed {
        opcode_t     opcode;
        logic [25:0] index;
    } j_instr_t;

    // One instruction word, read as R, I or J format
    typedef union packed {
        r_instr_t r;
        i_instr_t i;
        j_instr_t j;
    } instr_t;

    typedef struct packed {
        word_t      address;
        logic       read;
        logic       write;
        word_t      writedata;
        logic [3:0] byteenable;
    } bus_req_t;

    typedef struct packed {
        logic       en;
        logic [4:0] addr;
        word_t      data;
    } reg_wr_t;

endpackage
